// File: hw/obj_pkg.sv
package obj_pkg;

    // tile geometry
    localparam int TILE_SIZE = 16;
    localparam int PIXEL_BITS = 6;

    // framebuffer word layout, four 16-bit pixels per word
    localparam int LANES = 4;
    localparam int FB_WORD_BITS = 64;
    localparam int LANE_BITS = FB_WORD_BITS / LANES;

    // 8 line bits then 7 word-column bits
    localparam int FB_ADDR_BITS = 15;

    // 20 pixel slots per destination row leave room for an x shift of 3
    localparam int ROW_WORDS = 5;
    localparam int ROW_SLOTS = ROW_WORDS * LANES;

    // ROM words per tile
    localparam int BURST_4BPP = 16;
    localparam int BURST_6BPP = 32;

    // zoom byte of zero means full size
    localparam logic [8:0] ZOOM_FULL = 9'h100;

    typedef union packed {
        // four 4bpp groups of four nibbles
        logic [3:0][3:0][3:0] nib4;
        // two 6bpp groups, high pixel bits in 16..23, low nibbles in 0..15
        logic [1:0][31:0] grp6;
    } tile_rom_word_t;

endpackage

// File: hw/zoom_col_calc.sv
`timescale 1ns/100ps

module zoom_col_calc (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [7:0] zoom,
    output logic ready,
    output logic [4:0] count,
    output logic [obj_pkg::TILE_SIZE-1:0] valid,
    output logic [obj_pkg::TILE_SIZE-1:0][3:0] indices
);
    import obj_pkg::*;

    logic [8:0] step;
    logic [8:0] accum;
    logic [8:0] accum_next;
    logic [4:0] index;
    logic running;

    assign accum_next = accum + step;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
            running <= 1'b0;
        end else if (start) begin
            step <= (zoom == 8'd0) ? ZOOM_FULL : {1'b0, ~zoom};
            accum <= '0;
            index <= '0;
            count <= '0;
            valid <= '0;
            ready <= 1'b0;
            running <= 1'b1;
        end else if (running) begin
            if (index[4]) begin
                // all 16 source columns stepped
                ready <= 1'b1;
                running <= 1'b0;
            end else begin
                accum <= accum_next;
                index <= index + 5'd1;
                // a carry into bit 8 keeps this column
                if (accum_next[8] != accum[8]) begin
                    valid[count[3:0]] <= 1'b1;
                    indices[count[3:0]] <= index[3:0];
                    count <= count + 5'd1;
                end
            end
        end
    end

endmodule

// File: hw/zoom_row_calc.sv
`timescale 1ns/100ps

module zoom_row_calc (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [7:0] zoom,
    output logic ready,
    output logic [4:0] count,
    output logic [obj_pkg::TILE_SIZE-1:0] advance
);
    import obj_pkg::*;

    logic [8:0] step;
    logic [8:0] accum;
    logic [8:0] accum_next;
    logic [4:0] index;
    logic running;

    assign accum_next = accum + step;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
            running <= 1'b0;
        end else if (start) begin
            step <= (zoom == 8'd0) ? ZOOM_FULL : {1'b0, ~zoom};
            accum <= '0;
            index <= '0;
            count <= '0;
            advance <= '0;
            ready <= 1'b0;
            running <= 1'b1;
        end else if (running) begin
            if (index[4]) begin
                ready <= 1'b1;
                running <= 1'b0;
            end else begin
                accum <= accum_next;
                index <= index + 5'd1;
                // destination line moves on after this source row
                if (accum_next[8] != accum[8]) begin
                    advance[index[3:0]] <= 1'b1;
                    count <= count + 5'd1;
                end
            end
        end
    end

endmodule

// File: hw/tile_pixel_store.sv
`timescale 1ns/100ps

module tile_pixel_store (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic bpp6,
    input  logic load,
    input  obj_pkg::tile_rom_word_t din,
    input  logic [3:0] row_sel,
    output logic load_complete,
    output logic [obj_pkg::TILE_SIZE-1:0][obj_pkg::PIXEL_BITS-1:0] row_pixels
);
    import obj_pkg::*;

    logic [PIXEL_BITS-1:0] pix [TILE_SIZE*TILE_SIZE];
    logic [TILE_SIZE-1:0][PIXEL_BITS-1:0] word_pix;
    logic [TILE_SIZE-1:0][PIXEL_BITS-1:0] dec_pix;
    logic [7:0] dec_base;
    logic [4:0] burst_idx;
    logic burst_end;
    logic filling;
    logic dec_valid;
    logic dec_last;

    assign burst_end = bpp6 ? (burst_idx == 5'(BURST_6BPP - 1))
                            : (burst_idx == 5'(BURST_4BPP - 1));

    // 6bpp low nibbles come in the order 2, 3, 0, 1 within a group
    always_comb begin
        word_pix = '0;
        if (bpp6) begin
            for (int g = 0; g < 2; g++) begin
                for (int j = 0; j < 4; j++) begin
                    word_pix[g*4 + j] = {din.grp6[g][16 + 2*j +: 2],
                                         din.grp6[g][4*(j ^ 2) +: 4]};
                end
            end
        end else begin
            for (int g = 0; g < 4; g++) begin
                for (int n = 0; n < 4; n++) begin
                    word_pix[g*4 + n] = {2'b00, din.nib4[g][n]};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            burst_idx <= '0;
            filling <= 1'b0;
            dec_valid <= 1'b0;
            dec_last <= 1'b0;
            load_complete <= 1'b0;
        end else if (start) begin
            burst_idx <= '0;
            filling <= 1'b1;
            dec_valid <= 1'b0;
            dec_last <= 1'b0;
            load_complete <= 1'b0;
        end else begin
            dec_valid <= load && filling;
            dec_last <= load && filling && burst_end;
            if (load && filling) begin
                burst_idx <= burst_idx + 5'd1;
                if (burst_end) begin
                    filling <= 1'b0;
                end
            end
            if (dec_last) begin
                load_complete <= 1'b1;
            end
        end
    end

    // decoded word is written one cycle after it is taken
    always_ff @(posedge clk) begin
        dec_pix <= word_pix;
        dec_base <= bpp6 ? {burst_idx, 3'b000} : {burst_idx[3:0], 4'b0000};
        if (dec_valid) begin
            for (int k = 0; k < TILE_SIZE; k++) begin
                if (k < TILE_SIZE / 2 || !bpp6) begin
                    pix[dec_base + 8'(k)] <= dec_pix[k];
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < TILE_SIZE; c++) begin
            row_pixels[c] = pix[{row_sel, 4'(c)}];
        end
    end

endmodule

// File: hw/tile_row_composer.sv
`timescale 1ns/100ps

module tile_row_composer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic bpp6,
    input  logic flip_x,
    input  logic flip_y,
    input  logic [7:0] color,
    input  logic [11:0] x,
    input  logic [11:0] y,
    input  logic load_complete,
    input  logic col_ready,
    input  logic row_ready,
    input  logic [obj_pkg::TILE_SIZE-1:0] col_valid,
    input  logic [obj_pkg::TILE_SIZE-1:0][3:0] col_indices,
    input  logic [obj_pkg::TILE_SIZE-1:0] row_advance,
    output logic [3:0] row_sel,
    input  logic [obj_pkg::TILE_SIZE-1:0][obj_pkg::PIXEL_BITS-1:0] row_pixels,
    input  logic out_read,
    output logic out_ready,
    output logic [obj_pkg::FB_WORD_BITS-1:0] out_data,
    output logic [2*obj_pkg::LANES-1:0] out_be,
    output logic [obj_pkg::FB_ADDR_BITS-1:0] out_addr,
    output logic out_done
);
    import obj_pkg::*;

    logic [ROW_SLOTS-1:0][PIXEL_BITS-1:0] row_buf;
    logic [ROW_SLOTS-1:0][PIXEL_BITS-1:0] fresh_row;
    logic [FB_WORD_BITS-1:0] lane_data;
    logic [2*LANES-1:0] lane_be;
    logic [FB_ADDR_BITS-1:0] word_addr;
    logic [7:0] line;
    logic [3:0] row;
    logic [3:0] src_row;
    logic [3:0] row_offset;
    logic [2:0] col;
    logic primed;
    logic emit;

    // first word goes out unasked, the rest on each read
    assign emit = primed && (!out_ready || (out_read && !out_done));

    // row 0 while priming, otherwise the row after the current one
    assign src_row = primed ? row + 4'd1 : row;
    assign row_sel = flip_y ? ~src_row : src_row;

    assign line = y[7:0] + {4'd0, row_offset};
    assign word_addr = {line, 7'd0} + {8'd0, x[8:2]} + {12'd0, col};

    // kept column i lands at slot i plus the sub-word shift
    always_comb begin
        fresh_row = '0;
        for (int i = 0; i < TILE_SIZE; i++) begin
            if (col_valid[i]) begin
                fresh_row[i + int'(x[1:0])] =
                    row_pixels[flip_x ? ~col_indices[i] : col_indices[i]];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            if (bpp6) begin
                lane_data[LANE_BITS*l +: LANE_BITS] = {4'd0, color[7:2], row_buf[l]};
            end else begin
                lane_data[LANE_BITS*l +: LANE_BITS] = {4'd0, color, row_buf[l][3:0]};
            end
            // pixel 0 is transparent
            lane_be[2*l +: 2] = {2{|row_buf[l]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            primed <= 1'b0;
            out_ready <= 1'b0;
            out_done <= 1'b0;
            row <= '0;
            row_offset <= '0;
            col <= '0;
        end else if (!primed) begin
            if (load_complete && col_ready && row_ready) begin
                row_buf <= fresh_row;
                primed <= 1'b1;
            end
        end else if (emit) begin
            out_data <= lane_data;
            out_be <= lane_be;
            out_addr <= word_addr;
            out_ready <= 1'b1;
            if (col == 3'(ROW_WORDS - 1)) begin
                row_buf <= fresh_row;
                col <= '0;
                row <= row + 4'd1;
                if (row_advance[row]) begin
                    row_offset <= row_offset + 4'd1;
                end
                if (row == 4'(TILE_SIZE - 1)) begin
                    out_done <= 1'b1;
                end
            end else begin
                col <= col + 3'd1;
                for (int s = 0; s < ROW_SLOTS - LANES; s++) begin
                    row_buf[s] <= row_buf[s + LANES];
                end
                for (int s = ROW_SLOTS - LANES; s < ROW_SLOTS; s++) begin
                    row_buf[s] <= '0;
                end
            end
        end
    end

endmodule

// File: hw/obj_tile_renderer.sv
`timescale 1ns/100ps

module obj_tile_renderer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic bpp6,
    input  logic [7:0] x_zoom,
    input  logic [7:0] y_zoom,
    input  logic flip_x,
    input  logic flip_y,
    input  logic [7:0] color,
    input  logic [11:0] x,
    input  logic [11:0] y,
    input  logic load,
    input  obj_pkg::tile_rom_word_t din,
    input  logic out_read,
    output logic out_ready,
    output logic [obj_pkg::FB_WORD_BITS-1:0] out_data,
    output logic [2*obj_pkg::LANES-1:0] out_be,
    output logic [obj_pkg::FB_ADDR_BITS-1:0] out_addr,
    output logic out_done
);
    import obj_pkg::*;

    logic col_ready;
    logic row_ready;
    logic load_complete;
    logic [TILE_SIZE-1:0] col_valid;
    logic [TILE_SIZE-1:0][3:0] col_indices;
    logic [TILE_SIZE-1:0] row_advance;
    logic [3:0] row_sel;
    logic [TILE_SIZE-1:0][PIXEL_BITS-1:0] row_pixels;

    zoom_col_calc col_calc_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .zoom    (x_zoom),
        .ready   (col_ready),
        .count   (),
        .valid   (col_valid),
        .indices (col_indices)
    );

    zoom_row_calc row_calc_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .zoom    (y_zoom),
        .ready   (row_ready),
        .count   (),
        .advance (row_advance)
    );

    tile_pixel_store store_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .bpp6          (bpp6),
        .load          (load),
        .din           (din),
        .row_sel       (row_sel),
        .load_complete (load_complete),
        .row_pixels    (row_pixels)
    );

    tile_row_composer composer_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .bpp6          (bpp6),
        .flip_x        (flip_x),
        .flip_y        (flip_y),
        .color         (color),
        .x             (x),
        .y             (y),
        .load_complete (load_complete),
        .col_ready     (col_ready),
        .row_ready     (row_ready),
        .col_valid     (col_valid),
        .col_indices   (col_indices),
        .row_advance   (row_advance),
        .row_sel       (row_sel),
        .row_pixels    (row_pixels),
        .out_read      (out_read),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_be        (out_be),
        .out_addr      (out_addr),
        .out_done      (out_done)
    );

endmodule

// File: dv/obj_tile_renderer_properties.sv
`timescale 1ns/100ps

module obj_tile_renderer_properties (
    input logic clk,
    input logic reset,
    input logic start,
    input logic load_complete,
    input logic out_read,
    input logic out_ready,
    input logic [obj_pkg::FB_WORD_BITS-1:0] out_data,
    input logic [2*obj_pkg::LANES-1:0] out_be,
    input logic [obj_pkg::FB_ADDR_BITS-1:0] out_addr,
    input logic out_done
);
    import obj_pkg::*;

    logic [6:0] xfer_count;
    int prop_errors = 0;

    // words accepted before the last one
    always_ff @(posedge clk) begin
        if (reset || start) begin
            xfer_count <= '0;
        end else if (out_ready && out_read && !out_done) begin
            xfer_count <= xfer_count + 7'd1;
        end
    end

    assert property (@(posedge clk) reset |=> !out_ready && !out_done)
        else begin
            prop_errors++;
            $error("output handshake active after reset");
        end

    assert property (@(posedge clk) disable iff (reset) start |=> !out_ready && !out_done)
        else begin
            prop_errors++;
            $error("output handshake still active after a new start");
        end

    // nothing comes out until the tile is loaded
    assert property (@(posedge clk) disable iff (reset)
        !load_complete |-> !out_ready && !out_done)
        else begin
            prop_errors++;
            $error("output handshake active before the tile finished loading");
        end

    assert property (@(posedge clk) disable iff (reset)
        out_ready && !out_read |=> $stable(out_data) && $stable(out_be) && $stable(out_addr))
        else begin
            prop_errors++;
            $error("output word changed while it was not read");
        end

    assert property (@(posedge clk) disable iff (reset) out_ready && !start |=> out_ready)
        else begin
            prop_errors++;
            $error("out_ready dropped in the middle of a sprite");
        end

    assert property (@(posedge clk) disable iff (reset)
        $rose(out_done) |-> out_ready && xfer_count == 7'(TILE_SIZE * ROW_WORDS - 1))
        else begin
            prop_errors++;
            $error("out_done did not rise together with the last word");
        end

    assert property (@(posedge clk) disable iff (reset)
        out_done && !start |=> out_done && $stable(out_data) && $stable(out_be)
            && $stable(out_addr))
        else begin
            prop_errors++;
            $error("output changed after the last word");
        end

endmodule

// File: dv/obj_tile_renderer_tb.sv
`timescale 1ns/100ps

module obj_tile_renderer_tb;
    import obj_pkg::*;

    localparam int SPRITES = 6;
    localparam int CYCLES_PER_SPRITE = 400;
    localparam int CLK_PERIOD = 100;
    localparam int WORDS = TILE_SIZE * ROW_WORDS;

    logic clk;
    logic reset;
    logic start;
    logic bpp6;
    logic [7:0] x_zoom;
    logic [7:0] y_zoom;
    logic flip_x;
    logic flip_y;
    logic [7:0] color;
    logic [11:0] x;
    logic [11:0] y;
    logic load;
    tile_rom_word_t din;
    logic out_read;
    logic out_ready;
    logic [FB_WORD_BITS-1:0] out_data;
    logic [2*LANES-1:0] out_be;
    logic [FB_ADDR_BITS-1:0] out_addr;
    logic out_done;

    logic [31:0] lfsr_state;
    logic [63:0] tile_words [BURST_6BPP];
    logic [FB_WORD_BITS-1:0] exp_data [WORDS];
    logic [2*LANES-1:0] exp_be [WORDS];
    logic [FB_ADDR_BITS-1:0] exp_addr [WORDS];
    int data_errors;
    int be_errors;
    int addr_errors;
    int done_errors;

    obj_tile_renderer dut_i (.*);

    bind obj_tile_renderer obj_tile_renderer_properties props_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .load_complete (load_complete),
        .out_read      (out_read),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_be        (out_be),
        .out_addr      (out_addr),
        .out_done      (out_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'hA3000000 : 32'h0);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // bit i set when position i survives the zoom accumulator
    function automatic logic [15:0] zoom_keep(input logic [7:0] zoom);
        logic [8:0] step;
        logic [8:0] acc;
        logic [8:0] nxt;
        logic [15:0] keep;
        step = (zoom == 8'd0) ? ZOOM_FULL : 9'd255 - {1'b0, zoom};
        acc = '0;
        keep = '0;
        for (int i = 0; i < TILE_SIZE; i++) begin
            nxt = acc + step;
            keep[i] = nxt[8] ^ acc[8];
            acc = nxt;
        end
        return keep;
    endfunction

    function automatic logic [5:0] tile_pixel(input int r, input int c);
        logic [63:0] w;
        logic [31:0] grp;
        int p;
        int j;
        if (!bpp6) begin
            w = tile_words[r];
            return {2'b00, w[4*c +: 4]};
        end
        p = TILE_SIZE * r + c;
        w = tile_words[p / 8];
        grp = w[32*((p % 8) / 4) +: 32];
        j = p % 4;
        // low nibbles are swapped in pairs within a group
        return {grp[16 + 2*j +: 2], grp[4*((j + 2) % 4) +: 4]};
    endfunction

    task automatic build_expected();
        logic [15:0] col_keep;
        logic [15:0] row_keep;
        logic [PIXEL_BITS-1:0] slots [ROW_SLOTS];
        logic [PIXEL_BITS-1:0] pix;
        logic [7:0] line;
        int kept;
        int offset;
        int n;
        col_keep = zoom_keep(x_zoom);
        row_keep = zoom_keep(y_zoom);
        offset = 0;
        for (int r = 0; r < TILE_SIZE; r++) begin
            for (int s = 0; s < ROW_SLOTS; s++) begin
                slots[s] = '0;
            end
            kept = 0;
            for (int c = 0; c < TILE_SIZE; c++) begin
                if (col_keep[c]) begin
                    slots[kept + int'(x[1:0])] = tile_pixel(flip_y ? 15 - r : r,
                                                            flip_x ? 15 - c : c);
                    kept++;
                end
            end
            line = y[7:0] + 8'(offset);
            for (int w = 0; w < ROW_WORDS; w++) begin
                n = r * ROW_WORDS + w;
                exp_addr[n] = FB_ADDR_BITS'(int'({line, 7'd0}) + int'(x[8:2]) + w);
                for (int l = 0; l < LANES; l++) begin
                    pix = slots[LANES*w + l];
                    exp_data[n][LANE_BITS*l +: LANE_BITS] =
                        bpp6 ? {4'd0, color[7:2], pix} : {4'd0, color, pix[3:0]};
                    exp_be[n][2*l +: 2] = (pix != '0) ? 2'b11 : 2'b00;
                end
            end
            if (row_keep[r]) begin
                offset++;
            end
        end
    endtask

    task automatic check_word(input int n);
        assert (out_data == exp_data[n]) else begin
            data_errors++;
            $display("Fail %0t: word %0d out_data %h, expected %h",
                     $time, n, out_data, exp_data[n]);
        end
        assert (out_be == exp_be[n]) else begin
            be_errors++;
            $display("Fail %0t: word %0d out_be %b, expected %b", $time, n, out_be, exp_be[n]);
        end
        assert (out_addr == exp_addr[n]) else begin
            addr_errors++;
            $display("Fail %0t: word %0d out_addr %h, expected %h",
                     $time, n, out_addr, exp_addr[n]);
        end
        assert (out_done == (n == WORDS - 1)) else begin
            done_errors++;
            $display("Fail %0t: word %0d out_done %b", $time, n, out_done);
        end
    endtask

    task automatic fill_tile();
        for (int i = 0; i < BURST_6BPP; i++) begin
            tile_words[i] = random_bits(64);
        end
    endtask

    // one sprite, gaps puts random holes into out_read
    task automatic run_sprite(input logic gaps);
        int n;
        int words;
        build_expected();
        words = bpp6 ? BURST_6BPP : BURST_4BPP;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        n = 0;
        while (n < words) begin
            load = random_bits(2) != 64'd0;
            if (load) begin
                din = tile_words[n];
                n++;
            end
            @(negedge clk);
        end
        load = 1'b0;
        n = 0;
        while (n < WORDS) begin
            out_read = !gaps || (random_bits(1) != 64'd0);
            if (out_ready && out_read) begin
                check_word(n);
                n++;
            end
            @(negedge clk);
        end
        // extra reads after the last word change nothing
        out_read = 1'b1;
        repeat (3) @(negedge clk);
        assert (out_done && out_data == exp_data[WORDS-1]) else begin
            done_errors++;
            $display("Fail %0t: output moved on after the last word", $time);
        end
        out_read = 1'b0;
    endtask

    initial begin
        lfsr_state = 32'he8d8e297;
        data_errors = 0;
        be_errors = 0;
        addr_errors = 0;
        done_errors = 0;
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        bpp6 = 1'b0;
        x_zoom = 8'd0;
        y_zoom = 8'd0;
        flip_x = 1'b0;
        flip_y = 1'b0;
        color = 8'd0;
        x = 12'd0;
        y = 12'd0;
        load = 1'b0;
        din = '0;
        out_read = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        fill_tile();
        color = 8'(random_bits(8));
        x = 12'(random_bits(12));
        y = 12'(random_bits(12));
        run_sprite(1'b0);
        // same sprite again under back-pressure
        run_sprite(1'b1);

        flip_x = 1'b1;
        flip_y = 1'b1;
        x = {10'(random_bits(10)), 2'd3};
        run_sprite(1'b1);

        fill_tile();
        bpp6 = 1'b1;
        flip_x = 1'b0;
        flip_y = 1'b0;
        color = 8'(random_bits(8));
        x = {10'(random_bits(10)), 2'd1};
        run_sprite(1'b1);

        fill_tile();
        bpp6 = 1'b0;
        x_zoom = 8'h80;
        y_zoom = 8'h40;
        x = {10'(random_bits(10)), 2'd2};
        y = 12'(random_bits(12));
        run_sprite(1'b1);

        bpp6 = 1'b1;
        flip_x = 1'b1;
        x_zoom = 8'h40;
        y_zoom = 8'h80;
        run_sprite(1'b0);

        $display("errors: data %0d, byte enable %0d, address %0d, done %0d, handshake %0d",
                 data_errors, be_errors, addr_errors, done_errors,
                 dut_i.props_i.prop_errors);
        if (data_errors + be_errors + addr_errors + done_errors
                + dut_i.props_i.prop_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(SPRITES * CYCLES_PER_SPRITE * CLK_PERIOD);
        $display("the run timed out after %0d cycles without finishing",
                 SPRITES * CYCLES_PER_SPRITE);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: sources.f
hw/obj_pkg.sv
hw/zoom_col_calc.sv
hw/zoom_row_calc.sv
hw/tile_pixel_store.sv
hw/tile_row_composer.sv
hw/obj_tile_renderer.sv
dv/obj_tile_renderer_properties.sv
dv/obj_tile_renderer_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= obj_tile_renderer_tb
LOG ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
